//--- design/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Number of entries in the load reservation station.
`define LSU_LOAD_DEPTH 4

// Number of committed stores the store buffer can hold.
`define LSU_STORE_DEPTH 4

// Width of the destination tag carried by each load.
`define LSU_TAG_W 5

// Byte address width of the data-memory port.
`define LSU_ADDR_W 32

`endif

//--- design/lsu_pkg.sv
package lsu_pkg;

  // Access kinds seen by the memory port. Loads first, then stores.
  typedef enum logic [2:0] {
    OP_LB  = 3'd0,
    OP_LH  = 3'd1,
    OP_LW  = 3'd2,
    OP_LBU = 3'd3,
    OP_LHU = 3'd4,
    OP_SB  = 3'd5,
    OP_SH  = 3'd6,
    OP_SW  = 3'd7
  } mem_op_t;

  // Arbiter states. One wait state per kind of access in flight.
  typedef enum logic [1:0] {
    ARB_IDLE       = 2'd0,
    ARB_LOAD_WAIT  = 2'd1,
    ARB_STORE_WAIT = 2'd2
  } arb_state_t;

endpackage

//--- design/dmem_arbiter_fsm.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module dmem_arbiter_fsm
  import lsu_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       ld_rqst,
  input  logic                       st_rqst,
  input  logic [`LSU_LOAD_DEPTH-1:0] ld_sel_idx,
  input  logic                       dmem_resp,
  output logic                       dmem_req,
  output logic                       grant_load,
  output logic                       grant_store,
  output logic                       ld_pop,
  output logic                       st_pop,
  output logic [`LSU_LOAD_DEPTH-1:0] ld_done_idx
);

  arb_state_t state;
  arb_state_t next_state;

  // One-hot index of the load station entry whose access is in flight.
  logic [`LSU_LOAD_DEPTH-1:0] inflight_idx;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ARB_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight_idx <= '0;
    end else if (grant_load) begin
      inflight_idx <= ld_sel_idx;
    end else if (ld_pop) begin
      inflight_idx <= '0;
    end
  end

  always_comb begin
    next_state  = state;
    dmem_req    = 1'b0;
    grant_load  = 1'b0;
    grant_store = 1'b0;
    ld_pop      = 1'b0;
    st_pop      = 1'b0;
    ld_done_idx = '0;

    case (state)
      ARB_IDLE: begin
        // A flush holds off any new grant for this cycle.
        // Committed stores always go ahead of loads.
        if (!flush) begin
          if (st_rqst) begin
            dmem_req    = 1'b1;
            grant_store = 1'b1;
            next_state  = ARB_STORE_WAIT;
          end else if (ld_rqst) begin
            dmem_req    = 1'b1;
            grant_load  = 1'b1;
            next_state  = ARB_LOAD_WAIT;
          end
        end
      end

      ARB_LOAD_WAIT: begin
        if (dmem_resp) begin
          ld_pop      = 1'b1;
          ld_done_idx = inflight_idx;
          next_state  = ARB_IDLE;
        end
      end

      ARB_STORE_WAIT: begin
        if (dmem_resp) begin
          st_pop     = 1'b1;
          next_state = ARB_IDLE;
        end
      end

      default: begin
        next_state = ARB_IDLE;
      end
    endcase
  end

endmodule

//--- design/load_station.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module load_station
  import lsu_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       load_valid,
  input  mem_op_t                    load_op,
  input  logic [`LSU_ADDR_W-1:0]     load_addr,
  input  logic [`LSU_TAG_W-1:0]      load_tag,
  input  logic                       grant_load,
  input  logic                       ld_pop,
  input  logic [`LSU_LOAD_DEPTH-1:0] ld_done_idx,
  output logic                       load_full,
  output logic                       ld_rqst,
  output logic [`LSU_LOAD_DEPTH-1:0] ld_sel_idx,
  output mem_op_t                    ld_sel_op,
  output logic [`LSU_ADDR_W-1:0]     ld_sel_addr,
  output logic [`LSU_TAG_W-1:0]      ld_sel_tag
);

  localparam int DEPTH = `LSU_LOAD_DEPTH;
  localparam int AGE_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DEPTH-1:0]       valid;
  logic [DEPTH-1:0]       issued;
  // Age of an entry is the number of live entries younger than it.
  logic [AGE_W-1:0]       age [DEPTH];
  mem_op_t                op_q [DEPTH];
  logic [`LSU_ADDR_W-1:0] addr_q [DEPTH];
  logic [`LSU_TAG_W-1:0]  tag_q [DEPTH];

  logic                   alloc;
  logic [DEPTH-1:0]       alloc_hot;
  logic [DEPTH-1:0]       keep;
  logic [AGE_W-1:0]       sel_ptr;
  logic [AGE_W-1:0]       new_age [DEPTH];

  assign load_full = &valid;
  assign alloc     = load_valid && !load_full;

  // Lowest free slot takes the incoming load.
  always_comb begin
    alloc_hot = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (alloc && !valid[i]) begin
        alloc_hot = DEPTH'(1) << i;
      end
    end
  end

  // Oldest unissued entry wins, i.e. the one with the largest age.
  always_comb begin
    ld_rqst = 1'b0;
    sel_ptr = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (valid[i] && !issued[i] && (!ld_rqst || age[i] > age[sel_ptr])) begin
        ld_rqst = 1'b1;
        sel_ptr = AGE_W'(i);
      end
    end
  end

  assign ld_sel_idx  = ld_rqst ? (DEPTH'(1) << sel_ptr) : '0;
  assign ld_sel_op   = op_q[sel_ptr];
  assign ld_sel_addr = addr_q[sel_ptr];
  assign ld_sel_tag  = tag_q[sel_ptr];

  // Entries that survive this edge: not completed, and not dropped by a flush.
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      keep[i] = valid[i] && !(ld_pop && ld_done_idx[i]) && !(flush && !issued[i]);
    end
  end

  // Ages are recounted every cycle so they stay dense and never overflow.
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      new_age[i] = '0;
      for (int j = 0; j < DEPTH; j++) begin
        if (j != i && keep[j] && age[j] < age[i]) begin
          new_age[i] = new_age[i] + 1'b1;
        end
      end
      if (alloc) begin
        new_age[i] = new_age[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid  <= '0;
      issued <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        valid[i] <= keep[i] || alloc_hot[i];
        age[i]   <= new_age[i];
        if (alloc_hot[i]) begin
          issued[i] <= 1'b0;
          age[i]    <= '0;
        end else if (grant_load && ld_sel_idx[i]) begin
          issued[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (alloc_hot[i]) begin
        op_q[i]   <= load_op;
        addr_q[i] <= load_addr;
        tag_q[i]  <= load_tag;
      end
    end
  end

endmodule

//--- design/store_buffer.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module store_buffer
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   store_valid,
  input  mem_op_t                store_op,
  input  logic [`LSU_ADDR_W-1:0] store_addr,
  input  logic [31:0]            store_data,
  input  logic                   st_pop,
  output logic                   store_full,
  output logic                   st_rqst,
  output mem_op_t                st_op,
  output logic [`LSU_ADDR_W-1:0] st_addr,
  output logic [31:0]            st_data
);

  localparam int DEPTH = `LSU_STORE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  mem_op_t                op_mem [DEPTH];
  logic [`LSU_ADDR_W-1:0] addr_mem [DEPTH];
  logic [31:0]            data_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  // Wraps correctly for depths that are not a power of two.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = ptr + 1'b1;
    end
  endfunction

  assign store_full = (count == (PTR_W + 1)'(DEPTH));
  assign st_rqst    = (count != '0);
  assign push       = store_valid && !store_full;
  assign pop        = st_pop && st_rqst;

  assign st_op   = op_mem[rd_ptr];
  assign st_addr = addr_mem[rd_ptr];
  assign st_data = data_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr]   <= store_op;
      addr_mem[wr_ptr] <= store_addr;
      data_mem[wr_ptr] <= store_data;
    end
  end

endmodule

//--- design/dmem_port_mux.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module dmem_port_mux
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   grant_load,
  input  logic                   grant_store,
  input  mem_op_t                ld_sel_op,
  input  logic [`LSU_ADDR_W-1:0] ld_sel_addr,
  input  logic [`LSU_TAG_W-1:0]  ld_sel_tag,
  input  mem_op_t                st_op,
  input  logic [`LSU_ADDR_W-1:0] st_addr,
  input  logic [31:0]            st_data,
  input  logic                   dmem_resp,
  input  logic [31:0]            dmem_rdata,
  input  logic                   ld_pop,
  output logic                   dmem_we,
  output logic [`LSU_ADDR_W-1:0] dmem_addr,
  output logic [31:0]            dmem_wdata,
  output logic [3:0]             dmem_be,
  output logic                   load_done,
  output logic [`LSU_TAG_W-1:0]  load_done_tag,
  output logic [31:0]            load_done_data
);

  localparam int AW = `LSU_ADDR_W;

  logic                  grant;
  logic [AW-1:0]         addr_now;
  logic [3:0]            be_now;
  logic [31:0]           wdata_now;

  logic                  we_q;
  logic [AW-1:0]         addr_q;
  logic [3:0]            be_q;
  logic [31:0]           wdata_q;

  mem_op_t               ld_op_q;
  logic [1:0]            ld_off_q;
  logic [`LSU_TAG_W-1:0] ld_tag_q;
  logic [31:0]           rd_shift;

  function automatic logic [3:0] lane_mask(input mem_op_t op, input logic [1:0] off);
    case (op)
      OP_LB, OP_LBU, OP_SB: lane_mask = 4'b0001 << off;
      OP_LH, OP_LHU, OP_SH: lane_mask = 4'b0011 << {off[1], 1'b0};
      default:              lane_mask = 4'b1111;
    endcase
  endfunction

  assign grant = grant_load | grant_store;

  always_comb begin
    if (grant_store) begin
      addr_now  = st_addr;
      be_now    = lane_mask(st_op, st_addr[1:0]);
      wdata_now = st_data << {st_addr[1:0], 3'b000};
    end else begin
      addr_now  = ld_sel_addr;
      be_now    = lane_mask(ld_sel_op, ld_sel_addr[1:0]);
      wdata_now = '0;
    end
  end

  // The request is live during the grant cycle and held from the registers after it.
  assign dmem_we    = grant ? grant_store : we_q;
  assign dmem_addr  = grant ? {addr_now[AW-1:2], 2'b00} : addr_q;
  assign dmem_be    = grant ? be_now : be_q;
  assign dmem_wdata = grant ? wdata_now : wdata_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (grant) begin
      we_q <= grant_store;
    end else if (dmem_resp) begin
      we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      addr_q  <= {addr_now[AW-1:2], 2'b00};
      be_q    <= be_now;
      wdata_q <= wdata_now;
    end
    if (grant_load) begin
      ld_op_q  <= ld_sel_op;
      ld_off_q <= ld_sel_addr[1:0];
      ld_tag_q <= ld_sel_tag;
    end
  end

  // Bring the addressed lane down to bit 0, then extend.
  assign rd_shift = dmem_rdata >> {ld_off_q, 3'b000};

  always_comb begin
    case (ld_op_q)
      OP_LB:   load_done_data = {{24{rd_shift[7]}}, rd_shift[7:0]};
      OP_LBU:  load_done_data = {24'b0, rd_shift[7:0]};
      OP_LH:   load_done_data = {{16{rd_shift[15]}}, rd_shift[15:0]};
      OP_LHU:  load_done_data = {16'b0, rd_shift[15:0]};
      default: load_done_data = rd_shift;
    endcase
  end

  assign load_done     = ld_pop;
  assign load_done_tag = ld_tag_q;

endmodule

//--- design/lsu_mem_top.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_mem_top
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic                   load_valid,
  input  mem_op_t                load_op,
  input  logic [`LSU_ADDR_W-1:0] load_addr,
  input  logic [`LSU_TAG_W-1:0]  load_tag,
  output logic                   load_full,
  input  logic                   store_valid,
  input  mem_op_t                store_op,
  input  logic [`LSU_ADDR_W-1:0] store_addr,
  input  logic [31:0]            store_data,
  output logic                   store_full,
  output logic                   dmem_req,
  output logic                   dmem_we,
  output logic [`LSU_ADDR_W-1:0] dmem_addr,
  output logic [31:0]            dmem_wdata,
  output logic [3:0]             dmem_be,
  input  logic                   dmem_resp,
  input  logic [31:0]            dmem_rdata,
  output logic                   load_done,
  output logic [`LSU_TAG_W-1:0]  load_done_tag,
  output logic [31:0]            load_done_data
);

  logic                       ld_rqst;
  logic [`LSU_LOAD_DEPTH-1:0] ld_sel_idx;
  mem_op_t                    ld_sel_op;
  logic [`LSU_ADDR_W-1:0]     ld_sel_addr;
  logic [`LSU_TAG_W-1:0]      ld_sel_tag;
  logic                       st_rqst;
  mem_op_t                    st_op;
  logic [`LSU_ADDR_W-1:0]     st_addr;
  logic [31:0]                st_data;
  logic                       grant_load;
  logic                       grant_store;
  logic                       ld_pop;
  logic                       st_pop;
  logic [`LSU_LOAD_DEPTH-1:0] ld_done_idx;

  dmem_arbiter_fsm u_arb (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .ld_rqst(ld_rqst), .st_rqst(st_rqst), .ld_sel_idx(ld_sel_idx),
    .dmem_resp(dmem_resp), .dmem_req(dmem_req),
    .grant_load(grant_load), .grant_store(grant_store),
    .ld_pop(ld_pop), .st_pop(st_pop), .ld_done_idx(ld_done_idx)
  );

  load_station u_lds (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .load_valid(load_valid), .load_op(load_op), .load_addr(load_addr), .load_tag(load_tag),
    .grant_load(grant_load), .ld_pop(ld_pop), .ld_done_idx(ld_done_idx),
    .load_full(load_full), .ld_rqst(ld_rqst), .ld_sel_idx(ld_sel_idx),
    .ld_sel_op(ld_sel_op), .ld_sel_addr(ld_sel_addr), .ld_sel_tag(ld_sel_tag)
  );

  store_buffer u_stb (
    .clk(clk), .rst_n(rst_n),
    .store_valid(store_valid), .store_op(store_op),
    .store_addr(store_addr), .store_data(store_data), .st_pop(st_pop),
    .store_full(store_full), .st_rqst(st_rqst),
    .st_op(st_op), .st_addr(st_addr), .st_data(st_data)
  );

  dmem_port_mux u_mux (
    .clk(clk), .rst_n(rst_n),
    .grant_load(grant_load), .grant_store(grant_store),
    .ld_sel_op(ld_sel_op), .ld_sel_addr(ld_sel_addr), .ld_sel_tag(ld_sel_tag),
    .st_op(st_op), .st_addr(st_addr), .st_data(st_data),
    .dmem_resp(dmem_resp), .dmem_rdata(dmem_rdata), .ld_pop(ld_pop),
    .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_be(dmem_be),
    .load_done(load_done), .load_done_tag(load_done_tag), .load_done_data(load_done_data)
  );

endmodule

//--- verification/dmem_model.sv
`timescale 1ns/1ns

module dmem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req,
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  be,
  output logic        resp,
  output logic [31:0] rdata
);

  logic [31:0] mem [256];
  logic        busy;
  int          wait_left;
  logic        we_q;
  logic [7:0]  idx_q;
  logic [31:0] wdata_q;
  logic [3:0]  be_q;

  // Fill pattern depends on every bit of the word address.
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h0104_0401) ^ 32'h5a5a_c3c3;
    end
  end

  // Each request is answered 1 to 4 cycles later.
  always @(posedge clk) begin
    resp <= 1'b0;
    if (!rst_n) begin
      busy      <= 1'b0;
      wait_left <= 0;
      rdata     <= '0;
    end else if (req && !busy) begin
      busy      <= 1'b1;
      wait_left <= int'($urandom_range(3, 0));
      we_q      <= we;
      idx_q     <= addr[9:2];
      wdata_q   <= wdata;
      be_q      <= be;
    end else if (busy) begin
      if (wait_left == 0) begin
        resp <= 1'b1;
        busy <= 1'b0;
        if (we_q) begin
          for (int b = 0; b < 4; b++) begin
            if (be_q[b]) begin
              mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
            end
          end
        end else begin
          rdata <= mem[idx_q];
        end
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

endmodule

//--- verification/lsu_mem_tb.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_mem_tb
  import lsu_pkg::*;
();

  localparam int NUM_OPS    = 40;
  localparam int TIMEOUT_NS = (NUM_OPS * 10 + 200) * 20;

  logic clk = 1'b0;
  logic rst_n, flush, load_valid, store_valid;
  mem_op_t load_op, store_op;
  logic [`LSU_ADDR_W-1:0] load_addr, store_addr, dmem_addr;
  logic [`LSU_TAG_W-1:0] load_tag, load_done_tag;
  logic [31:0] store_data, dmem_wdata, dmem_rdata, load_done_data;
  logic load_full, store_full, dmem_req, dmem_we, dmem_resp, load_done;
  logic [3:0] dmem_be;

  int errors = 0;
  int n_loads = 0;
  int n_stores = 0;
  int st_pend, ld_pend, next_tag;
  logic busy_q, ld_inflight, no_grant, rejected_set;
  logic [7:0] inflight_word;
  logic [`LSU_TAG_W-1:0] rejected_tag;
  logic pend_valid [32];
  mem_op_t pend_op [32];
  logic [31:0] pend_addr [32];
  logic [31:0] shadow [256];
  mem_op_t sq_op [$];
  logic [31:0] sq_addr [$];
  logic [31:0] sq_data [$];

  lsu_mem_top DUT (.*);

  dmem_model u_mem (
    .clk(clk), .rst_n(rst_n), .req(dmem_req), .we(dmem_we), .addr(dmem_addr),
    .wdata(dmem_wdata), .be(dmem_be), .resp(dmem_resp), .rdata(dmem_rdata)
  );

  always #10 clk = ~clk;

  task automatic flag_failure(input string what);
    errors++;
    $display("Check failed at %0t ns: %s", $time, what);
  endtask

  task automatic flag_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("ERROR: %s expected 0x%h, got 0x%h at %0t ns", name, exp, act, $time);
  endtask

  // Lanes covered by a store are size bytes starting at the byte offset.
  function automatic logic [3:0] store_lanes(input mem_op_t op, input logic [1:0] off);
    int size;
    logic [3:0] m;
    size = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
    m = '0;
    for (int b = 0; b < 4; b++) begin
      if (b >= int'(off) && b < int'(off) + size) m[b] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic [31:0] place_bytes(input logic [31:0] data, input logic [1:0] off);
    logic [31:0] r;
    r = '0;
    for (int b = int'(off); b < 4; b++) begin
      r[8*b +: 8] = data[8*(b - int'(off)) +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] expected_load(input mem_op_t op, input logic [31:0] word,
                                                input logic [1:0] off);
    logic [7:0] bt;
    logic [15:0] hw;
    bt = word[8*off +: 8];
    hw = (off[1]) ? word[31:16] : word[15:0];
    case (op)
      OP_LB:   return {{24{bt[7]}}, bt};
      OP_LBU:  return {24'h0, bt};
      OP_LH:   return {{16{hw[15]}}, hw};
      OP_LHU:  return {16'h0, hw};
      default: return word;
    endcase
  endfunction

  function automatic logic [31:0] align_addr(input mem_op_t op, input logic [31:0] raw);
    case (op)
      OP_SW, OP_LW:         return raw & 32'h0000_03fc;
      OP_SH, OP_LH, OP_LHU: return raw & 32'h0000_03fe;
      default:              return raw & 32'h0000_03ff;
    endcase
  endfunction

  always @(posedge clk) begin
    logic [3:0] ebe;
    logic [31:0] mask, exp;
    mem_op_t op;
    logic [31:0] addr, data;
    if (!rst_n) begin
      busy_q = 1'b0;
      ld_inflight = 1'b0;
      no_grant = 1'b0;
      st_pend = 0;
      ld_pend = 0;
    end else begin
      if (dmem_req) begin
        assert (!busy_q) else flag_failure("dmem_req issued while an access was in flight");
        assert (dmem_we || st_pend == 0) else flag_failure("load granted while stores waited");
      end
      if (dmem_req && dmem_we && sq_op.size() == 0) begin
        flag_failure("store granted with no store outstanding");
      end else if (dmem_req && dmem_we) begin
        op = sq_op.pop_front();
        addr = sq_addr.pop_front();
        data = sq_data.pop_front();
        ebe = store_lanes(op, addr[1:0]);
        mask = {{8{ebe[3]}}, {8{ebe[2]}}, {8{ebe[1]}}, {8{ebe[0]}}};
        exp = place_bytes(data, addr[1:0]);
        assert (dmem_be == ebe) else flag_mismatch("dmem_be", 32'(ebe), 32'(dmem_be));
        assert ((dmem_wdata & mask) == (exp & mask))
          else flag_mismatch("dmem_wdata", exp & mask, dmem_wdata & mask);
        assert (dmem_addr == (addr & ~32'h3))
          else flag_mismatch("dmem_addr", addr & ~32'h3, dmem_addr);
        shadow[addr[9:2]] = (shadow[addr[9:2]] & ~mask) | (exp & mask);
        st_pend--;
        n_stores++;
      end
      if (dmem_req && !dmem_we) begin
        assert (!no_grant) else flag_failure("load granted after the flush emptied the station");
        inflight_word = dmem_addr[9:2];
        ld_inflight = 1'b1;
      end
      if (dmem_req) busy_q = 1'b1;
      else if (dmem_resp) busy_q = 1'b0;
      if (load_done) begin
        assert (!(rejected_set && load_done_tag == rejected_tag))
          else flag_failure("a load offered while the station was full came back");
        assert (pend_valid[load_done_tag])
          else flag_failure("load_done returned a tag that is not outstanding");
        if (pend_valid[load_done_tag]) begin
          addr = pend_addr[load_done_tag];
          exp = expected_load(pend_op[load_done_tag], shadow[addr[9:2]], addr[1:0]);
          assert (load_done_data == exp) else flag_mismatch("load_done_data", exp, load_done_data);
          pend_valid[load_done_tag] = 1'b0;
          ld_pend--;
          n_loads++;
        end
        ld_inflight = 1'b0;
      end
      if (store_valid && !store_full) begin
        sq_op.push_back(store_op);
        sq_addr.push_back(store_addr);
        sq_data.push_back(store_data);
        st_pend++;
      end
      if (load_valid && !load_full) begin
        pend_valid[load_tag] = 1'b1;
        pend_op[load_tag] = load_op;
        pend_addr[load_tag] = load_addr;
        ld_pend++;
        no_grant = 1'b0;
      end
      // Flush drops every waiting load; only the one on the port survives.
      if (flush) begin
        for (int t = 0; t < 32; t++) begin
          if (pend_valid[t] && !(ld_inflight && pend_addr[t][9:2] == inflight_word)) begin
            pend_valid[t] = 1'b0;
            ld_pend--;
          end
        end
        no_grant = 1'b1;
      end
    end
  end

  task automatic send_store(input mem_op_t op, input logic [31:0] addr, input logic [31:0] data);
    while (store_full) begin
      @(posedge clk);
      #2;
    end
    store_valid = 1'b1;
    store_op = op;
    store_addr = addr;
    store_data = data;
    @(posedge clk);
    #2;
    store_valid = 1'b0;
  endtask

  task automatic send_load(input mem_op_t op, input logic [31:0] addr);
    while (load_full) begin
      @(posedge clk);
      #2;
    end
    load_valid = 1'b1;
    load_op = op;
    load_addr = addr;
    load_tag = `LSU_TAG_W'(next_tag);
    next_tag++;
    @(posedge clk);
    #2;
    load_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (st_pend != 0 || ld_pend != 0 || busy_q) begin
      @(posedge clk);
      #2;
    end
  endtask

  function automatic mem_op_t random_store_op();
    case ($urandom_range(2, 0))
      0:       return OP_SB;
      1:       return OP_SH;
      default: return OP_SW;
    endcase
  endfunction

  function automatic mem_op_t random_load_op();
    case ($urandom_range(4, 0))
      0:       return OP_LB;
      1:       return OP_LH;
      2:       return OP_LW;
      3:       return OP_LBU;
      default: return OP_LHU;
    endcase
  endfunction

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    mem_op_t op;
    int next_word;
    void'($urandom(19500));
    rst_n = 1'b0;
    flush = 1'b0;
    load_valid = 1'b0;
    store_valid = 1'b0;
    load_op = OP_LW;
    store_op = OP_SW;
    load_addr = '0;
    store_addr = '0;
    load_tag = '0;
    store_data = '0;
    next_tag = 0;
    rejected_set = 1'b0;
    rejected_tag = '0;
    for (int t = 0; t < 32; t++) pend_valid[t] = 1'b0;
    repeat (5) @(posedge clk);
    for (int i = 0; i < 256; i++) shadow[i] = u_mem.mem[i];
    #2;
    rst_n = 1'b1;
    assert (!dmem_req && !load_done && !load_full && !store_full)
      else flag_failure("outputs not idle after reset");

    repeat (12) begin
      op = random_store_op();
      send_store(op, align_addr(op, $urandom), $urandom);
    end
    wait_drained();

    repeat (12) begin
      op = random_load_op();
      send_load(op, align_addr(op, $urandom));
    end
    wait_drained();

    // Stores and loads offered together; stores keep the port, so the station fills.
    for (int k = 0; k < 4; k++) begin
      op = random_store_op();
      store_valid = 1'b1;
      store_op = op;
      store_addr = align_addr(op, $urandom);
      store_data = $urandom;
      op = random_load_op();
      load_valid = 1'b1;
      load_op = op;
      load_addr = align_addr(op, $urandom);
      load_tag = `LSU_TAG_W'(next_tag);
      next_tag++;
      @(posedge clk);
      #2;
    end
    store_valid = 1'b0;
    assert (load_full) else flag_failure("load station not full after four loads");
    rejected_tag = `LSU_TAG_W'(next_tag);
    rejected_set = 1'b1;
    next_tag++;
    load_tag = rejected_tag;
    load_addr = 32'h0000_0100;
    load_op = OP_LW;
    @(posedge clk);
    #2;
    load_valid = 1'b0;
    wait_drained();

    for (int k = 0; k < 4; k++) begin
      send_load(OP_LW, 32'h0000_0200 + 32'(k * 4));
    end
    // Top the station up until it is full behind a load on the port.
    next_word = 4;
    while (!(ld_inflight && load_full)) begin
      if (!load_full) begin
        send_load(OP_LW, 32'h0000_0200 + 32'(next_word * 4));
        next_word++;
      end else begin
        @(posedge clk);
        #2;
      end
    end
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
    assert (!load_full) else flag_failure("load station still full after flush");
    wait_drained();

    $display("Run complete: %0d errors, %0d stores, %0d loads", errors, n_stores, n_loads);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- lsu_mem_top.f
+incdir+design
design/lsu_pkg.sv
design/dmem_arbiter_fsm.sv
design/load_station.sv
design/store_buffer.sv
design/dmem_port_mux.sv
design/lsu_mem_top.sv
verification/dmem_model.sv
verification/lsu_mem_tb.sv

//--- run.sh
#!/bin/sh
# Builds the LSU memory-port testbench with Verilator, runs it and scans the log.

rm -rf obj_dir sim.log build.log

verilator --binary --assert --top-module lsu_mem_tb -f lsu_mem_top.f -o lsu_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/lsu_sim > sim.log 2>&1 || echo "Simulator returned a non-zero status"
cat sim.log

test -s sim.log && ! grep -q "TEST FAILED" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }
